// File: Makefile
# Verilator build and run of the color mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_colmix
FLIST     ?= colmix.f
OBJ_DIR   ?= obj_dir
BIN       ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: colmix.f
src/colmix_pkg.sv
src/pal_ram.sv
src/pal_apb_port.sv
src/layer_prio.sv
src/video_blank.sv
src/s16_colmix.sv
tb/colmix_assert.sv
tb/tb_colmix.sv

// File: src/colmix_pkg.sv
// ----------------------------------------
// color mixer package
// widths, priority classes, layer pixel
// structs and the palette word decoding
// ----------------------------------------
package colmix_pkg;

    localparam int pal_aw = 11;             // 2048 palette entries
    localparam int pal_dw = 16;             // palette word width

    // sprite class that lets a sprite cover each tile layer
    localparam logic [1:0] obj_prio_char = 2'd3;
    localparam logic [1:0] obj_prio_scr1 = 2'd2;
    localparam logic [1:0] obj_prio_scr2 = 2'd1;

    // text layer pixel, 7 bits
    typedef struct packed {
        logic       prio;                   // tile over sprite
        logic [5:0] color;                  // low 4 bits = pixel code
    } char_pxl_t;

    // scroll layer pixel, 11 bits
    typedef struct packed {
        logic       prio;
        logic [9:0] idx;                    // low 4 bits = pixel code
    } scr_pxl_t;

    // sprite pixel, 12 bits
    typedef struct packed {
        logic [1:0] prio;                   // priority class
        logic [9:0] idx;
    } obj_pxl_t;

    // palette address, upper half of the RAM holds sprite colors
    typedef struct packed {
        logic       obj;
        logic [9:0] idx;
    } pal_addr_t;

    // one palette word, seen raw by the cpu or split into color fields
    typedef union packed {
        logic [pal_dw-1:0] raw;
        struct packed {
            logic       unused;
            logic       b_lo;               // low-order color bits
            logic       g_lo;
            logic       r_lo;
            logic [3:0] b;
            logic [3:0] g;
            logic [3:0] r;
        } f;
    } pal_word_u;

    // 15-bit output color
    typedef struct packed {
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } rgb_t;

    // all four layers for one pixel, 41 bits
    typedef struct packed {
        char_pxl_t char_pxl;
        scr_pxl_t  scr1_pxl;
        scr_pxl_t  scr2_pxl;
        obj_pxl_t  obj_pxl;
    } layer_set_t;

endpackage

// File: src/layer_prio.sv
// ----------------------------------------
// layer priority
// gates the layers, merges sprites into
// each tile layer, picks the palette entry
// ----------------------------------------
`timescale 1ns/1ps

module layer_prio
    import colmix_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic [3:0] gfx_en,      // 0 char, 1 scr1, 2 scr2, 3 obj
    input  layer_set_t layers,
    output pal_addr_t  pal_addr
);

    char_pxl_t char_g;
    scr_pxl_t  scr1_g;
    scr_pxl_t  scr2_g;
    obj_pxl_t  obj_g;

    pal_addr_t lyr_char;            // merged text layer
    pal_addr_t lyr_scr1;
    pal_addr_t lyr_scr2;

    // sprite wins if it draws, has this layer's class
    // and the tile does not claim priority
    function automatic pal_addr_t tile_or_obj(
        input obj_pxl_t   spr,
        input logic [9:0] tile,
        input logic       tile_prio,
        input logic [1:0] cls
    );
        pal_addr_t sel;
        if (spr.idx[3:0] != 4'd0 && spr.prio == cls && !tile_prio) begin
            sel.obj = 1'b1;
            sel.idx = spr.idx;
        end else begin
            sel.obj = 1'b0;
            sel.idx = tile;
        end
        return sel;
    endfunction

    // sprites test 4 code bits, tiles only 3
    function automatic logic opaque(input pal_addr_t lyr);
        logic op;
        if (lyr.obj) begin
            op = lyr.idx[3:0] != 4'd0;
        end else begin
            op = lyr.idx[2:0] != 3'd0;
        end
        return op;
    endfunction

    // debug enables clear the pixel code only
    always_comb begin
        char_g = layers.char_pxl;
        scr1_g = layers.scr1_pxl;
        scr2_g = layers.scr2_pxl;
        obj_g  = layers.obj_pxl;
        if (!gfx_en[0]) char_g.color[3:0] = 4'd0;
        if (!gfx_en[1]) scr1_g.idx[3:0]   = 4'd0;
        if (!gfx_en[2]) scr2_g.idx[3:0]   = 4'd0;
        if (!gfx_en[3]) obj_g.idx[3:0]    = 4'd0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lyr_char <= '0;
            lyr_scr1 <= '0;
            lyr_scr2 <= '0;
        end else if (pxl_cen) begin
            lyr_char <= tile_or_obj(obj_g, {4'd0, char_g.color}, char_g.prio, obj_prio_char);
            lyr_scr1 <= tile_or_obj(obj_g, scr1_g.idx, scr1_g.prio, obj_prio_scr1);
            lyr_scr2 <= tile_or_obj(obj_g, scr2_g.idx, scr2_g.prio, obj_prio_scr2);
        end
    end

    // front to back, scr2 is the backdrop
    always_comb begin
        if (opaque(lyr_char)) begin
            pal_addr = lyr_char;
        end else if (opaque(lyr_scr1)) begin
            pal_addr = lyr_scr1;
        end else begin
            pal_addr = lyr_scr2;
        end
    end

endmodule

// File: src/pal_apb_port.sv
// ----------------------------------------
// APB slave for the palette
// writes with no wait, reads with one,
// odd byte addresses answer with pslverr
// ----------------------------------------
`timescale 1ns/1ps

module pal_apb_port
    import colmix_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // APB
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,      // byte address
    input  logic [15:0] pwdata,
    input  logic [1:0]  pstrb,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // palette RAM port A
    output pal_addr_t   a_addr,
    output logic [15:0] a_wdata,
    output logic [1:0]  a_we,
    input  logic [15:0] a_rdata
);

    typedef enum logic {
        rd_idle,
        rd_wait
    } rd_state_t;

    rd_state_t rd_state;
    logic      access;              // access phase
    logic      misaligned;

    assign access     = psel && penable;
    assign misaligned = paddr[0];

    // address goes out already in the setup cycle
    assign a_addr  = paddr[pal_aw:1];
    assign a_wdata = pwdata;
    assign a_we    = (access && pwrite && !misaligned) ? pstrb : 2'b00;

    // first read access cycle waits, RAM data is there in the second
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (access && !pwrite && !misaligned) rd_state <= rd_wait;
                rd_wait: rd_state <= rd_idle;  // transfer ends here
                default: rd_state <= rd_idle;
            endcase
        end
    end

    assign pready  = access && (pwrite || misaligned || rd_state == rd_wait);
    assign pslverr = access && misaligned;
    assign prdata  = (rd_state == rd_wait) ? a_rdata : 16'd0;

endmodule

// File: src/pal_ram.sv
// ----------------------------------------
// palette RAM, 2048 x 16
// port A byte writes for the cpu, port B
// read only for video, registered reads
// ----------------------------------------
`timescale 1ns/1ps

module pal_ram
    import colmix_pkg::*;
(
    input  logic        clk,
    // cpu side
    input  pal_addr_t   a_addr,
    input  logic [15:0] a_wdata,
    input  logic [1:0]  a_we,       // one bit per byte
    output logic [15:0] a_rdata,
    // video side
    input  pal_addr_t   b_addr,
    output pal_word_u   b_rdata
);

    logic [pal_dw-1:0] mem [0:2**pal_aw-1];

    // port A writes per byte lane and reads the old data
    always_ff @(posedge clk) begin
        if (a_we[0]) begin
            mem[a_addr][7:0] <= a_wdata[7:0];   // low byte
        end
        if (a_we[1]) begin
            mem[a_addr][15:8] <= a_wdata[15:8]; // high byte
        end
        a_rdata <= mem[a_addr];
    end

    // port B is read only
    always_ff @(posedge clk) begin
        b_rdata.raw <= mem[b_addr];
    end

endmodule

// File: src/s16_colmix.sv
// ----------------------------------------
// s16 color mixer top
// APB palette port, palette RAM, layer
// priority and blanking stage
// ----------------------------------------
`timescale 1ns/1ps

module s16_colmix
    import colmix_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic        video_en,
    input  logic [3:0]  gfx_en,
    input  logic        hblank,
    input  logic        vblank,
    input  layer_set_t  layers,
    // APB palette access
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [15:0] pwdata,
    input  logic [1:0]  pstrb,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // video out
    output rgb_t        rgb,
    output logic        hblank_dly,
    output logic        vblank_dly
);

    pal_addr_t   a_addr;            // cpu port
    logic [15:0] a_wdata;
    logic [1:0]  a_we;
    logic [15:0] a_rdata;
    pal_addr_t   pal_addr;          // video port
    pal_word_u   pal;

    pal_apb_port i_apb (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .a_addr  (a_addr),
        .a_wdata (a_wdata),
        .a_we    (a_we),
        .a_rdata (a_rdata)
    );

    pal_ram i_ram (
        .clk     (clk),
        .a_addr  (a_addr),
        .a_wdata (a_wdata),
        .a_we    (a_we),
        .a_rdata (a_rdata),
        .b_addr  (pal_addr),
        .b_rdata (pal)
    );

    layer_prio i_prio (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .layers   (layers),
        .pal_addr (pal_addr)
    );

    video_blank i_blank (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .video_en   (video_en),
        .hblank     (hblank),
        .vblank     (vblank),
        .pal        (pal),
        .rgb        (rgb),
        .hblank_dly (hblank_dly),
        .vblank_dly (vblank_dly)
    );

endmodule

// File: src/video_blank.sv
// ----------------------------------------
// video enable and blanking stage
// one pixel delay for color and blanks,
// color forced black while blanking
// ----------------------------------------
`timescale 1ns/1ps

module video_blank
    import colmix_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pxl_cen,
    input  logic      video_en,
    input  logic      hblank,       // active low
    input  logic      vblank,       // active low
    input  pal_word_u pal,
    output rgb_t      rgb,
    output logic      hblank_dly,
    output logic      vblank_dly
);

    pal_word_u pal_g;               // after video enable
    rgb_t      rgb_next;

    always_comb begin
        pal_g.raw = video_en ? pal.raw : 16'd0;
        // 4-bit field on top, extra low bit below it
        rgb_next.r = {pal_g.f.r, pal_g.f.r_lo};
        rgb_next.g = {pal_g.f.g, pal_g.f.g_lo};
        rgb_next.b = {pal_g.f.b, pal_g.f.b_lo};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb        <= '0;
            hblank_dly <= 1'b0;     // blanking until first pixel
            vblank_dly <= 1'b0;
        end else if (pxl_cen) begin
            hblank_dly <= hblank;
            vblank_dly <= vblank;
            rgb        <= (hblank && vblank) ? rgb_next : '0;
        end
    end

endmodule

// File: tb/colmix_assert.sv
// ----------------------------------------
// color mixer checker, bound into the top
// shadow palette, reference priority and
// blanking model, concurrent assertions
// ----------------------------------------
`timescale 1ns/1ps

module colmix_assert
    import colmix_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        pxl_cen,
    input logic        video_en,
    input logic [3:0]  gfx_en,
    input logic        hblank,
    input logic        vblank,
    input layer_set_t  layers,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [11:0] paddr,
    input logic [15:0] pwdata,
    input logic [1:0]  pstrb,
    input logic [15:0] prdata,
    input logic        pready,
    input logic        pslverr,
    input logic [1:0]  a_we,            // RAM write strobe inside the top
    input rgb_t        rgb,
    input logic        hblank_dly,
    input logic        vblank_dly
);

    int          fail_count = 0;    // failed assertions so far
    logic [15:0] shadow [0:2047];
    logic [1:0]  acc_cycles;        // access cycles spent without pready
    logic [10:0] ref_addr;          // model winner, one pixel late
    logic [15:0] ref_word;          // model of the video port read
    rgb_t        ref_rgb;
    logic        ref_hb;
    logic        ref_vb;
    logic        access;

    assign access = psel && penable;

    // sprite takes the layer if it draws with the class and the tile has no prio
    function automatic logic [10:0] merge(input obj_pxl_t spr, input logic [9:0] tile,
                                          input logic tile_prio, input logic [1:0] cls);
        if (spr.idx[3:0] != 4'd0 && spr.prio == cls && !tile_prio) begin
            return {1'b1, spr.idx};
        end
        return {1'b0, tile};
    endfunction

    function automatic logic drawn(input logic [10:0] e);
        return e[10] ? (e[3:0] != 4'd0) : (e[2:0] != 3'd0);   // sprites test 4 bits and tiles 3
    endfunction

    function automatic logic [10:0] winner(input layer_set_t l, input logic [3:0] en);
        char_pxl_t   ch;
        scr_pxl_t    s1;
        scr_pxl_t    s2;
        obj_pxl_t    ob;
        logic [10:0] m0;
        logic [10:0] m1;
        logic [10:0] m2;
        ch = l.char_pxl;
        s1 = l.scr1_pxl;
        s2 = l.scr2_pxl;
        ob = l.obj_pxl;
        if (!en[0]) ch.color[3:0] = 4'd0;
        if (!en[1]) s1.idx[3:0] = 4'd0;
        if (!en[2]) s2.idx[3:0] = 4'd0;
        if (!en[3]) ob.idx[3:0] = 4'd0;
        m0 = merge(ob, {4'd0, ch.color}, ch.prio, 2'd3);
        m1 = merge(ob, s1.idx, s1.prio, 2'd2);
        m2 = merge(ob, s2.idx, s2.prio, 2'd1);
        if (drawn(m0)) return m0;
        if (drawn(m1)) return m1;
        return m2;                  // backdrop
    endfunction

    always_ff @(posedge clk) begin
        if (access && pwrite && !paddr[0]) begin
            if (pstrb[0]) shadow[paddr[11:1]][7:0] <= pwdata[7:0];
            if (pstrb[1]) shadow[paddr[11:1]][15:8] <= pwdata[15:8];
        end
        if (!rst_n || !access || pready) acc_cycles <= 2'd0;
        else acc_cycles <= acc_cycles + 2'd1;
        ref_word <= shadow[ref_addr];   // old data on a same-cycle write
        if (!rst_n) begin
            ref_addr <= '0;
            ref_rgb  <= '0;
            ref_hb   <= 1'b0;
            ref_vb   <= 1'b0;
        end else if (pxl_cen) begin
            ref_addr <= winner(layers, gfx_en);
            ref_hb   <= hblank;
            ref_vb   <= vblank;
            // word bits 14:12 are the low bits of b, g, r
            ref_rgb  <= (hblank && vblank && video_en) ?
                        {ref_word[3:0], ref_word[12], ref_word[7:4], ref_word[13],
                         ref_word[11:8], ref_word[14]} : '0;
        end
    end

    a_reset_out: assert property (@(posedge clk)
        !rst_n |=> rgb == '0 && !hblank_dly && !vblank_dly)
        else begin $error("video outputs not cleared by reset"); fail_count++; end
    a_reset_bus: assert property (@(posedge clk) !rst_n |-> !pready && !pslverr)
        else begin $error("pready or pslverr high during reset"); fail_count++; end
    a_wr_nowait: assert property (@(posedge clk) access && pwrite |-> pready)
        else begin $error("mismatch at %0t: pready is %b, expected 1 on write",
                          $time, $sampled(pready)); fail_count++; end
    a_rd_onewait: assert property (@(posedge clk)
        access && !pwrite && !paddr[0] |-> pready == (acc_cycles == 2'd1))
        else begin $error("mismatch at %0t: pready is %b, expected %b on read", $time,
                          $sampled(pready), $sampled(acc_cycles) == 2'd1); fail_count++; end
    a_rd_data: assert property (@(posedge clk)
        access && !pwrite && !paddr[0] && pready |-> prdata == shadow[paddr[11:1]])
        else begin $error("mismatch at %0t: prdata is %h, expected %h", $time,
                          $sampled(prdata), shadow[$sampled(paddr[11:1])]); fail_count++; end
    a_odd_addr: assert property (@(posedge clk)
        access && paddr[0] |-> pready && pslverr && a_we == 2'b00)
        else begin $error("odd address did not end with pslverr or wrote the RAM"); fail_count++; end
    a_no_err: assert property (@(posedge clk) access && !paddr[0] |-> !pslverr)
        else begin $error("pslverr high on an aligned transfer"); fail_count++; end
    a_rgb: assert property (@(posedge clk) rst_n |-> rgb == ref_rgb)
        else begin $error("mismatch at %0t: rgb is %h, expected %h", $time,
                          $sampled(rgb), $sampled(ref_rgb)); fail_count++; end
    a_blank_dly: assert property (@(posedge clk)
        rst_n |-> hblank_dly == ref_hb && vblank_dly == ref_vb)
        else begin $error("mismatch at %0t: hblank_dly,vblank_dly is %b%b, expected %b%b",
                          $time, $sampled(hblank_dly), $sampled(vblank_dly),
                          $sampled(ref_hb), $sampled(ref_vb)); fail_count++; end
    a_blank_black: assert property (@(posedge clk) !hblank_dly || !vblank_dly |-> rgb == '0)
        else begin $error("rgb not black during blanking"); fail_count++; end

endmodule

bind s16_colmix colmix_assert i_chk (.*);

// File: tb/tb_colmix.sv
// ----------------------------------------
// color mixer testbench
// APB palette traffic, random layers and
// blanking, verdict from the bound checker
// ----------------------------------------
`timescale 1ns/1ps

module tb_colmix
    import colmix_pkg::*;
();

    localparam int fill_words = 2048;
    localparam int rand_pix   = 400;
    localparam int gfx_pix    = 60;
    localparam int blank_pix  = 200;
    // up to 4 clocks per APB transfer, 2 per pixel, plus slack
    localparam int max_cycles = 20 + 4 * (fill_words + 40)
                              + 2 * (rand_pix + 5 * gfx_pix + blank_pix) + 200;

    logic        clk        = 1'b0;
    logic        rst_n      = 1'b0;
    logic        pxl_cen    = 1'b0;
    logic        video_en   = 1'b1;
    logic [3:0]  gfx_en     = 4'hf;
    logic        hblank     = 1'b0;     // blanking active at start
    logic        vblank     = 1'b0;
    layer_set_t  layers     = '0;
    logic        psel       = 1'b0;
    logic        penable    = 1'b0;
    logic        pwrite     = 1'b0;
    logic [11:0] paddr      = '0;
    logic [15:0] pwdata     = '0;
    logic [1:0]  pstrb      = '0;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    rgb_t        rgb;
    logic        hblank_dly;
    logic        vblank_dly;
    integer      seed       = 32'h8ed1;
    int          cycles     = 0;
    int          tests      = 0;
    int          last_fails = 0;

    s16_colmix i_dut (.*);

    always #4 clk = ~clk;
    always @(posedge clk) pxl_cen <= !pxl_cen;  // every second clock

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, test sequence did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // odd multiplier, so every index gets its own 15-bit color
    function automatic logic [15:0] fill_word(input logic [10:0] idx);
        return {5'd0, idx} * 16'h2d1 + 16'h1357;
    endfunction

    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [15:0] data, input logic [1:0] strb);
        @(posedge clk);
        psel    <= 1'b1;                // setup
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        do @(posedge clk); while (!pready);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_word(input logic [11:0] addr, input logic [15:0] data,
                              input logic [1:0] strb);
        apb_transfer(1'b1, addr, data, strb);
    endtask

    task automatic read_word(input logic [11:0] addr);
        apb_transfer(1'b0, addr, 16'd0, 2'b00);
    endtask

    // new layers at each pixel enable, blanks random if asked
    task automatic drive_pixels(input int n, input logic rand_blank);
        logic [63:0] rnd;
        repeat (n) begin
            do @(posedge clk); while (!pxl_cen);
            rnd = {$random(seed), $random(seed)};
            layers <= rnd[40:0];
            if (rand_blank) begin
                hblank <= rnd[43:41] != 3'd0;
                vblank <= rnd[47:44] != 4'd0;
            end
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs       = i_dut.i_chk.fail_count - last_fails;
        last_fails = i_dut.i_chk.fail_count;
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errs);
    endtask

    initial begin
        logic [31:0] rnd;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        finish_test("reset values");

        for (int i = 0; i < fill_words; i++) begin
            write_word(12'(i * 2), fill_word(11'(i)), 2'b11);
        end
        write_word(12'h010, 16'hffff, 2'b11);
        write_word(12'h010, 16'h1234, 2'b01);   // low byte only
        write_word(12'h012, 16'habcd, 2'b10);   // high byte only
        write_word(12'h014, 16'h5555, 2'b00);   // no lane
        write_word(12'h017, 16'hdead, 2'b11);   // odd, must not land
        read_word(12'h010);
        read_word(12'h012);
        read_word(12'h014);
        read_word(12'h016);
        read_word(12'h017);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            write_word({rnd[10:0], 1'b0}, rnd[31:16], rnd[12:11]);
            read_word({rnd[10:0], 1'b0});
        end
        finish_test("apb access");

        hblank <= 1'b1;
        vblank <= 1'b1;
        drive_pixels(rand_pix, 1'b0);
        finish_test("random layers");

        for (int b = 0; b < 4; b++) begin
            gfx_en <= ~(4'b0001 << b);
            drive_pixels(gfx_pix, 1'b0);
        end
        gfx_en   <= 4'hf;
        video_en <= 1'b0;
        drive_pixels(gfx_pix, 1'b0);
        video_en <= 1'b1;
        finish_test("layer and video enables");

        drive_pixels(blank_pix, 1'b1);
        hblank <= 1'b1;
        vblank <= 1'b1;
        drive_pixels(2, 1'b0);
        finish_test("blanking");

        repeat (4) @(posedge clk);
        $display("%0d tests, %0d assertion failures", tests, i_dut.i_chk.fail_count);
        if (i_dut.i_chk.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
